// File: sim.f
src/qu_pkg.sv
src/operand_if.sv
src/dispatch_ctrl.sv
src/rob_tracker.sv
src/busy_table.sv
src/phy_reg_file.sv
src/rename_stage.sv
src/dispatch_top.sv
dv/dispatch_props.sv
dv/dispatch_checker.sv
dv/dispatch_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timing
TOP       = dispatch_tb
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/dispatch_tb.sv
// Dispatch slice testbench
`default_nettype none

module dispatch_tb;
    import qu_pkg::*;

    localparam int CLK_PERIOD = 40;
    // reset, scrub, and an upper bound on the traffic phases
    localparam int PLANNED_CYCLES = 2 + PHY_RF_DEPTH + 1 + 270;

    logic         clk, rst;
    logic         uop_valid, uop_rd_valid, uop_imm_valid, uop_ready;
    op_t          uop_op, rs_op;
    phy_reg_t     uop_rd, uop_rs1, uop_rs2, uop_phyreg_old;
    word_t        uop_imm, uop_pc;
    logic         wb_valid, commit;
    phy_reg_t     wb_phyreg;
    word_t        wb_data;
    logic         rs_wr_en, rs_rj, rs_rk;
    res_st_addr_t rs_wr_addr;
    word_t        rs_vj, rs_vk, rs_a, rs_pc;
    rob_addr_t    rs_qj, rs_qk, rs_rob_addr;
    phy_reg_t     rs_dest, rs_phyreg_old;
    int           value_errors, other_errors;
    logic [31:0]  lcg_state;
    int           in_flight;

    dispatch_top u_dut (.*);

    dispatch_checker u_chk (.*);

    bind dispatch_ctrl dispatch_props u_props (
        .clk, .rst, .state, .uop_valid, .uop_ready, .dispatch, .scrub_en
    );

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    // offered uop stays on the bus until the DUT accepts it
    task automatic send_uop(input phy_reg_t rd, input logic rd_valid, input phy_reg_t rs1,
                            input phy_reg_t rs2, input logic imm_valid);
        uop_valid      <= 1'b1;
        uop_op         <= op_t'(next_rand());
        uop_rd         <= rd;
        uop_rd_valid   <= rd_valid;
        uop_rs1        <= rs1;
        uop_rs2        <= rs2;
        uop_imm        <= next_rand();
        uop_imm_valid  <= imm_valid;
        uop_pc         <= next_rand();
        uop_phyreg_old <= phy_reg_t'(next_rand());
        do
            @(posedge clk);
        while (!uop_ready);
        uop_valid <= 1'b0;
        in_flight++;
    endtask

    task automatic write_back(input phy_reg_t r, input word_t d);
        wb_valid  <= 1'b1;
        wb_phyreg <= r;
        wb_data   <= d;
        @(posedge clk);
        wb_valid <= 1'b0;
    endtask

    task automatic commit_one();
        commit <= 1'b1;
        @(posedge clk);
        commit <= 1'b0;
        in_flight--;
    endtask

    task automatic drain();
        while (in_flight > 0)
            commit_one();
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(PLANNED_CYCLES * 2 * CLK_PERIOD);
        $display("run timed out after %0d cycles without finishing", PLANNED_CYCLES * 2);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        word_t r;
        rst            = 1'b1;
        uop_valid      = 1'b0;
        uop_op         = '0;
        uop_rd         = '0;
        uop_rd_valid   = 1'b0;
        uop_rs1        = '0;
        uop_rs2        = '0;
        uop_imm        = '0;
        uop_imm_valid  = 1'b0;
        uop_pc         = '0;
        uop_phyreg_old = '0;
        wb_valid       = 1'b0;
        wb_phyreg      = '0;
        wb_data        = '0;
        commit         = 1'b0;
        lcg_state      = 32'h874ddf2e;
        in_flight      = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // first uops after the scrub see zero ready operands
        send_uop(5'd1, 1'b0, 5'd2, 5'd3, 1'b1);
        send_uop(5'd4, 1'b0, 5'd5, 5'd31, 1'b0);

        // settled registers carry written values
        for (int i = 1; i <= 8; i++)
            write_back(phy_reg_t'(i), next_rand());
        for (int i = 0; i < 4; i++)
        begin
            r = next_rand();
            send_uop(5'd0, 1'b0, phy_reg_t'(r[2:0] + 3'd1), phy_reg_t'(r[6:4] + 3'd1), r[8]);
        end
        drain();

        // outstanding producers, then their writebacks
        send_uop(5'd10, 1'b1, 5'd1, 5'd2, 1'b1);
        send_uop(5'd12, 1'b1, 5'd10, 5'd3, 1'b0);
        send_uop(5'd13, 1'b0, 5'd4, 5'd12, 1'b1);
        write_back(5'd10, next_rand());
        write_back(5'd12, next_rand());
        send_uop(5'd14, 1'b0, 5'd10, 5'd12, 1'b0);

        // writeback and a new producer of one register on the same edge
        fork
            send_uop(5'd10, 1'b1, 5'd10, 5'd12, 1'b0);
            write_back(5'd10, next_rand());
        join
        send_uop(5'd15, 1'b0, 5'd10, 5'd3, 1'b1);

        // mixed traffic
        for (int i = 0; i < 24; i++)
        begin
            r = next_rand();
            send_uop(phy_reg_t'(r), r[5], phy_reg_t'(r >> 8), phy_reg_t'(r >> 16), r[6]);
            if (r[7])
                write_back(phy_reg_t'(r >> 24), next_rand());
            if (in_flight > 8)
                commit_one();
        end
        drain();

        // fill the reorder buffer, the next uop waits for a commit
        for (int i = 0; i < ROB_DEPTH; i++)
            send_uop(phy_reg_t'(i), 1'b0, phy_reg_t'(i + 1), phy_reg_t'(i + 2), 1'b1);
        fork
            send_uop(5'd7, 1'b0, 5'd7, 5'd8, 1'b0);
            begin
                idle(4);
                commit_one();
            end
        join
        drain();

        // gaps in uop_valid between accepted uops
        for (int i = 0; i < 10; i++)
        begin
            r = next_rand();
            idle(int'(r[1:0]));
            send_uop(phy_reg_t'(r >> 4), 1'b0, phy_reg_t'(r >> 12), phy_reg_t'(r >> 20), r[2]);
            if (in_flight > 8)
                commit_one();
        end

        // masked destination and immediate
        // register 20 starts settled
        write_back(5'd20, next_rand());
        send_uop(5'd20, 1'b0, 5'd20, 5'd21, 1'b0);
        send_uop(5'd21, 1'b0, 5'd20, 5'd21, 1'b1);
        drain();
        idle(2);

        $display("value errors %0d, other errors %0d, assertion failures %0d",
                 value_errors, other_errors, u_dut.u_ctrl.u_props.fails);
        if (value_errors + other_errors + int'(u_dut.u_ctrl.u_props.fails) == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/dispatch_checker.sv
// Dispatch reference model and compare
`default_nettype none

module dispatch_checker (
    input  logic                 clk, rst,
    input  logic                 uop_valid, uop_rd_valid, uop_imm_valid,
    input  qu_pkg::op_t          uop_op,
    input  qu_pkg::phy_reg_t     uop_rd, uop_rs1, uop_rs2, uop_phyreg_old,
    input  qu_pkg::word_t        uop_imm, uop_pc,
    input  logic                 wb_valid, commit,
    input  qu_pkg::phy_reg_t     wb_phyreg,
    input  qu_pkg::word_t        wb_data,
    input  logic                 uop_ready, rs_wr_en, rs_rj, rs_rk,
    input  qu_pkg::res_st_addr_t rs_wr_addr,
    input  qu_pkg::op_t          rs_op,
    input  qu_pkg::word_t        rs_vj, rs_vk, rs_a, rs_pc,
    input  qu_pkg::rob_addr_t    rs_qj, rs_qk, rs_rob_addr,
    input  qu_pkg::phy_reg_t     rs_dest, rs_phyreg_old,
    output int                   value_errors, other_errors
);
    import qu_pkg::*;

    // {ready, tag, value} of one source operand
    typedef logic [WORD_WIDTH+ROB_ADDR_WIDTH:0] operand_t;

    localparam int READY_BIT = WORD_WIDTH + ROB_ADDR_WIDTH;

    // mirrored slice state
    logic         busy [PHY_RF_DEPTH];
    rob_addr_t    tags [PHY_RF_DEPTH];
    word_t        regs [PHY_RF_DEPTH];
    int           rob_count;
    rob_addr_t    tail;
    res_st_addr_t rs_ptr;
    logic         ready_seen;
    int           low_cycles;

    // a pending source waits on its producer, a settled one carries its value
    function automatic operand_t ref_operand(input phy_reg_t r);
        if (busy[r])
            return {1'b0, tags[r], word_t'(0)};
        return {1'b1, rob_addr_t'(0), regs[r]};
    endfunction

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    always @(posedge clk)
    begin
        logic     exp_ready;
        logic     accept;
        operand_t opj;
        operand_t opk;
        if (rst)
        begin
            // the scrub leaves every register at zero
            for (int i = 0; i < PHY_RF_DEPTH; i++)
            begin
                busy[i] = 1'b0;
                regs[i] = '0;
            end
            rob_count    = 0;
            tail         = '0;
            rs_ptr       = '0;
            ready_seen   = 1'b0;
            low_cycles   = 0;
            value_errors = 0;
            other_errors = 0;
        end
        else
        begin
            // release edge plus one zero write per register
            if (!ready_seen && uop_ready)
            begin
                ready_seen = 1'b1;
                if (low_cycles != PHY_RF_DEPTH + 1)
                begin
                    $display("uop_ready came up after %0d cycles instead of %0d",
                             low_cycles, PHY_RF_DEPTH + 1);
                    other_errors++;
                end
            end
            else if (!ready_seen)
                low_cycles++;

            exp_ready = ready_seen && (rob_count != ROB_DEPTH);
            accept    = uop_valid && exp_ready;
            check_field("uop_ready", 32'(exp_ready), 32'(uop_ready));
            check_field("rs_wr_en", 32'(accept), 32'(rs_wr_en));

            if (accept)
            begin
                opj = ref_operand(uop_rs1);
                opk = ref_operand(uop_rs2);
                check_field("rs_wr_addr", 32'(rs_ptr), 32'(rs_wr_addr));
                check_field("rs_rob_addr", 32'(tail), 32'(rs_rob_addr));
                check_field("rs_op", 32'(uop_op), 32'(rs_op));
                check_field("rs_rj", 32'(opj[READY_BIT]), 32'(rs_rj));
                check_field("rs_qj", 32'(opj[WORD_WIDTH +: ROB_ADDR_WIDTH]), 32'(rs_qj));
                check_field("rs_vj", opj[WORD_WIDTH-1:0], rs_vj);
                check_field("rs_rk", 32'(opk[READY_BIT]), 32'(rs_rk));
                check_field("rs_qk", 32'(opk[WORD_WIDTH +: ROB_ADDR_WIDTH]), 32'(rs_qk));
                check_field("rs_vk", opk[WORD_WIDTH-1:0], rs_vk);
                check_field("rs_a", uop_imm_valid ? uop_imm : 32'h0, rs_a);
                check_field("rs_dest", 32'(uop_rd_valid ? uop_rd : phy_reg_t'(0)),
                            32'(rs_dest));
                check_field("rs_phyreg_old", 32'(uop_phyreg_old), 32'(rs_phyreg_old));
                check_field("rs_pc", uop_pc, rs_pc);
            end

            // writeback first so that a new producer of the same register wins
            if (wb_valid)
            begin
                busy[wb_phyreg] = 1'b0;
                regs[wb_phyreg] = wb_data;
            end
            if (accept)
            begin
                if (uop_rd_valid)
                begin
                    busy[uop_rd] = 1'b1;
                    tags[uop_rd] = tail;
                end
                // both wrap by their width
                tail   = tail + 1'b1;
                rs_ptr = rs_ptr + 1'b1;
            end
            if (commit && !accept && rob_count == 0)
            begin
                $display("commit arrived while the reorder buffer was empty");
                other_errors++;
            end
            rob_count = rob_count + int'(accept) - int'(commit);
        end
    end

endmodule

`default_nettype wire

// File: dv/dispatch_props.sv
// Dispatch controller assertions
`default_nettype none

module dispatch_props (
    input logic                clk,
    input logic                rst,
    input qu_pkg::ctrl_state_t state,
    input logic                uop_valid,
    input logic                uop_ready,
    input logic                dispatch,
    input logic                scrub_en
);
    import qu_pkg::*;

    // number of failed assertions
    int unsigned fails = 0;

    a_no_ready_in_scrub: assert property (
        @(posedge clk) disable iff (rst) (state == CTRL_SCRUB) |-> !uop_ready)
    else
    begin
        $error("uop_ready is high while the register file is being scrubbed");
        fails++;
    end

    a_dispatch_handshake: assert property (
        @(posedge clk) disable iff (rst) dispatch |-> (uop_ready && uop_valid))
    else
    begin
        $error("dispatch pulse without both uop_ready and uop_valid");
        fails++;
    end

    a_scrub_only_in_scrub: assert property (
        @(posedge clk) disable iff (rst) (state != CTRL_SCRUB) |-> !scrub_en)
    else
    begin
        $error("scrub write enable is active outside the scrub phase");
        fails++;
    end

endmodule

`default_nettype wire

// File: src/dispatch_top.sv
// Dispatch slice top level
`default_nettype none

module dispatch_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 uop_valid,
    input  qu_pkg::op_t          uop_op,
    input  qu_pkg::phy_reg_t     uop_rd,
    input  logic                 uop_rd_valid,
    input  qu_pkg::phy_reg_t     uop_rs1,
    input  qu_pkg::phy_reg_t     uop_rs2,
    input  qu_pkg::word_t        uop_imm,
    input  logic                 uop_imm_valid,
    input  qu_pkg::word_t        uop_pc,
    input  qu_pkg::phy_reg_t     uop_phyreg_old,
    input  logic                 wb_valid,
    input  qu_pkg::phy_reg_t     wb_phyreg,
    input  qu_pkg::word_t        wb_data,
    input  logic                 commit,
    output logic                 uop_ready,
    output logic                 rs_wr_en,
    output qu_pkg::res_st_addr_t rs_wr_addr,
    output qu_pkg::op_t          rs_op,
    output qu_pkg::word_t        rs_vj,
    output qu_pkg::word_t        rs_vk,
    output qu_pkg::rob_addr_t    rs_qj,
    output qu_pkg::rob_addr_t    rs_qk,
    output logic                 rs_rj,
    output logic                 rs_rk,
    output qu_pkg::word_t        rs_a,
    output qu_pkg::phy_reg_t     rs_dest,
    output qu_pkg::phy_reg_t     rs_phyreg_old,
    output qu_pkg::word_t        rs_pc,
    output qu_pkg::rob_addr_t    rs_rob_addr
);
    import qu_pkg::*;

    logic      dispatch;
    logic      rob_full;
    rob_addr_t rob_tail;
    logic      scrub_en;
    phy_reg_t  scrub_addr;
    logic      busy_set_en;

    operand_if ops ();

    dispatch_ctrl u_ctrl (
        .clk, .rst, .uop_valid, .commit, .rob_full,
        .uop_ready, .dispatch, .scrub_en, .scrub_addr
    );

    rob_tracker u_rob (
        .clk, .rst, .dispatch, .commit,
        .tail (rob_tail), .rob_full
    );

    busy_table u_busy (
        .clk, .rst, .ops (ops.busy_side),
        .set_en (busy_set_en), .set_reg (uop_rd),
        .wb_valid, .wb_phyreg
    );

    phy_reg_file u_prf (
        .clk, .ops (ops.data_side),
        .wb_valid, .wb_phyreg, .wb_data, .scrub_en, .scrub_addr
    );

    rename_stage u_rename (
        .clk, .rst, .dispatch,
        .uop_op, .uop_rd, .uop_rd_valid, .uop_imm, .uop_imm_valid,
        .uop_pc, .uop_phyreg_old, .rob_tail, .ops (ops.rename),
        .uop_rs1, .uop_rs2,
        .rs_wr_en, .rs_wr_addr, .rs_op, .rs_vj, .rs_vk, .rs_qj, .rs_qk,
        .rs_rj, .rs_rk, .rs_a, .rs_dest, .rs_phyreg_old, .rs_pc,
        .rs_rob_addr, .busy_set_en
    );

endmodule

`default_nettype wire

// File: src/rename_stage.sv
// Operand rename and dispatch entry build
`default_nettype none

module rename_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispatch,
    input  qu_pkg::op_t          uop_op,
    input  qu_pkg::phy_reg_t     uop_rd,
    input  logic                 uop_rd_valid,
    input  qu_pkg::word_t        uop_imm,
    input  logic                 uop_imm_valid,
    input  qu_pkg::word_t        uop_pc,
    input  qu_pkg::phy_reg_t     uop_phyreg_old,
    input  qu_pkg::rob_addr_t    rob_tail,
    operand_if.rename            ops,
    input  qu_pkg::phy_reg_t     uop_rs1,
    input  qu_pkg::phy_reg_t     uop_rs2,
    output logic                 rs_wr_en,
    output qu_pkg::res_st_addr_t rs_wr_addr,
    output qu_pkg::op_t          rs_op,
    output qu_pkg::word_t        rs_vj,
    output qu_pkg::word_t        rs_vk,
    output qu_pkg::rob_addr_t    rs_qj,
    output qu_pkg::rob_addr_t    rs_qk,
    output logic                 rs_rj,
    output logic                 rs_rk,
    output qu_pkg::word_t        rs_a,
    output qu_pkg::phy_reg_t     rs_dest,
    output qu_pkg::phy_reg_t     rs_phyreg_old,
    output qu_pkg::word_t        rs_pc,
    output qu_pkg::rob_addr_t    rs_rob_addr,
    output logic                 busy_set_en
);
    import qu_pkg::*;

    // producer tag of each physical register, valid while its busy bit is set
    rob_addr_t    tag_list [PHY_RF_DEPTH];
    res_st_addr_t wr_ptr;

    assign ops.rs1 = uop_rs1;
    assign ops.rs2 = uop_rs2;

    // a busy source waits on its producer tag, otherwise it carries the value
    always_comb
    begin
        rs_rj = !ops.busy1;
        rs_qj = ops.busy1 ? tag_list[uop_rs1] : '0;
        rs_vj = ops.busy1 ? '0 : ops.data1;

        rs_rk = !ops.busy2;
        rs_qk = ops.busy2 ? tag_list[uop_rs2] : '0;
        rs_vk = ops.busy2 ? '0 : ops.data2;
    end

    assign rs_a          = uop_imm_valid ? uop_imm : '0;
    assign rs_dest       = uop_rd_valid ? uop_rd : '0;
    assign rs_op         = uop_op;
    assign rs_pc         = uop_pc;
    assign rs_phyreg_old = uop_phyreg_old;
    assign rs_rob_addr   = rob_tail;
    assign rs_wr_addr    = wr_ptr;
    assign rs_wr_en      = dispatch;
    assign busy_set_en   = dispatch && uop_rd_valid;

    always_ff @(posedge clk)
    begin
        if (busy_set_en)
        begin
            tag_list[uop_rd] <= rob_tail;
        end
    end

    // wraps modulo RES_ST_DEPTH
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
        end
        else if (dispatch)
        begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/phy_reg_file.sv
// Physical register file
`default_nettype none

module phy_reg_file (
    input  logic             clk,
    operand_if.data_side     ops,
    input  logic             wb_valid,
    input  qu_pkg::phy_reg_t wb_phyreg,
    input  qu_pkg::word_t    wb_data,
    input  logic             scrub_en,
    input  qu_pkg::phy_reg_t scrub_addr
);
    import qu_pkg::*;

    word_t    regs [PHY_RF_DEPTH];

    logic     wr_en;
    phy_reg_t wr_addr;
    word_t    wr_data;

    // one write port shared by writeback and the scrub
    always_comb
    begin
        wr_en   = wb_valid || scrub_en;
        wr_addr = wb_valid ? wb_phyreg : scrub_addr;
        wr_data = wb_valid ? wb_data : '0;
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational read ports
    assign ops.data1 = regs[ops.rs1];
    assign ops.data2 = regs[ops.rs2];

endmodule

`default_nettype wire

// File: src/busy_table.sv
// Physical register busy table
`default_nettype none

module busy_table (
    input  logic             clk,
    input  logic             rst,
    operand_if.busy_side     ops,
    input  logic             set_en,
    input  qu_pkg::phy_reg_t set_reg,
    input  logic             wb_valid,
    input  qu_pkg::phy_reg_t wb_phyreg
);
    import qu_pkg::*;

    logic [PHY_RF_DEPTH-1:0] busy;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= '0;
        end
        else
        begin
            if (wb_valid)
            begin
                busy[wb_phyreg] <= 1'b0;
            end
            // set comes last so a new producer wins over a writeback
            if (set_en)
            begin
                busy[set_reg] <= 1'b1;
            end
        end
    end

    // no bypass of this cycle's writeback
    assign ops.busy1 = busy[ops.rs1];
    assign ops.busy2 = busy[ops.rs2];

endmodule

`default_nettype wire

// File: src/rob_tracker.sv
// Reorder buffer occupancy tracker
`default_nettype none

module rob_tracker (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch,
    input  logic              commit,
    output qu_pkg::rob_addr_t tail,
    output logic              rob_full
);
    import qu_pkg::*;

    // one extra bit so that a full buffer is distinct from an empty one
    logic [ROB_ADDR_WIDTH:0] count;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tail  <= '0;
            count <= '0;
        end
        else
        begin
            // tail wraps modulo ROB_DEPTH by its width
            if (dispatch)
            begin
                tail <= tail + 1'b1;
            end

            case ({dispatch, commit})
                2'b10:
                begin
                    count <= count + 1'b1;
                end
                2'b01:
                begin
                    count <= count - 1'b1;
                end
                default:
                begin
                    count <= count;
                end
            endcase
        end
    end

    assign rob_full = (count == (ROB_ADDR_WIDTH + 1)'(ROB_DEPTH));

endmodule

`default_nettype wire

// File: src/dispatch_ctrl.sv
// Dispatch controller
`default_nettype none

module dispatch_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             uop_valid,
    input  logic             commit,
    input  logic             rob_full,
    output logic             uop_ready,
    output logic             dispatch,
    output logic             scrub_en,
    output qu_pkg::phy_reg_t scrub_addr
);
    import qu_pkg::*;

    ctrl_state_t state;
    phy_reg_t    scrub_idx;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= CTRL_SCRUB;
            scrub_idx <= '0;
            scrub_en  <= 1'b0;
        end
        else
        begin
            case (state)
                CTRL_SCRUB:
                begin
                    // one zero write per cycle, last one on index 31
                    scrub_en <= 1'b1;
                    if (scrub_en)
                    begin
                        scrub_idx <= scrub_idx + 1'b1;
                        if (scrub_idx == phy_reg_t'(PHY_RF_DEPTH - 1))
                        begin
                            scrub_en <= 1'b0;
                            state    <= CTRL_RUN;
                        end
                    end
                end
                CTRL_RUN:
                begin
                    // a commit in the same cycle frees a slot at once
                    if (rob_full && !commit)
                    begin
                        state <= CTRL_FULL;
                    end
                end
                CTRL_FULL:
                begin
                    if (commit)
                    begin
                        state <= CTRL_RUN;
                    end
                end
                default:
                begin
                    state <= CTRL_SCRUB;
                end
            endcase
        end
    end

    // rob_full also masks ready in the cycle the buffer fills up
    assign uop_ready  = (state == CTRL_RUN) && !rob_full;
    assign dispatch   = uop_valid && uop_ready;
    assign scrub_addr = scrub_idx;

endmodule

`default_nettype wire

// File: src/operand_if.sv
// Source operand lookup bundle
`default_nettype none

interface operand_if;
    import qu_pkg::*;

    // source register addresses
    phy_reg_t rs1;
    phy_reg_t rs2;

    // pending-write bits of the sources
    logic     busy1;
    logic     busy2;

    // register file values of the sources
    word_t    data1;
    word_t    data2;

    modport rename (output rs1, rs2, input busy1, busy2, data1, data2);

    modport busy_side (input rs1, rs2, output busy1, busy2);

    modport data_side (input rs1, rs2, output data1, data2);

endinterface

`default_nettype wire

// File: src/qu_pkg.sv
// Dispatch slice shared definitions
`default_nettype none

package qu_pkg;

    // physical register file
    localparam int PHY_RF_DEPTH      = 32;
    localparam int PHY_RF_ADDR_WIDTH = 5;

    // reorder buffer
    localparam int ROB_DEPTH      = 16;
    localparam int ROB_ADDR_WIDTH = 4;

    // reservation station
    localparam int RES_ST_DEPTH      = 8;
    localparam int RES_ST_ADDR_WIDTH = 3;

    // datapath
    localparam int WORD_WIDTH = 32;
    localparam int OP_WIDTH   = 6;

    // physical register number
    typedef logic [PHY_RF_ADDR_WIDTH-1:0] phy_reg_t;

    // reorder buffer slot, also the producer tag of an operand
    typedef logic [ROB_ADDR_WIDTH-1:0] rob_addr_t;

    // reservation station slot
    typedef logic [RES_ST_ADDR_WIDTH-1:0] res_st_addr_t;

    // data word or pc
    typedef logic [WORD_WIDTH-1:0] word_t;

    // operation code
    typedef logic [OP_WIDTH-1:0] op_t;

    // dispatch controller phases
    // scrub clears the register file once after reset,
    // full is entered when the reorder buffer has no free slot
    typedef enum logic [1:0] {
        CTRL_SCRUB,
        CTRL_RUN,
        CTRL_FULL
    } ctrl_state_t;

endpackage

`default_nettype wire
